/* rtl/l2_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 memory shared definitions
// Widths and stream payloads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package l2_pkg;

  // Word and address geometry
  localparam int unsigned DataWidth      = 32;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned TagWidth       = 4;   // Chosen by the requester
  localparam int unsigned ByteOffsetBits = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [TagWidth-1:0]  tag_t;

  // Request payload, one word per transfer
  typedef struct packed {
    addr_t addr;   // Byte address, low bits only are decoded
    logic  write;
    data_t wdata;
    strb_t strb;   // Byte enables, writes only
    tag_t  tag;
  } l2_req_t;

  // Response payload, zero data on write acks
  typedef struct packed {
    data_t rdata;
    tag_t  tag;
  } l2_rsp_t;

endpackage

`default_nettype wire

/* rtl/l2_bank_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 bank port
// Request and response streams of one bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface l2_bank_if
  import l2_pkg::*;
#(
  parameter int unsigned NumMasters = 4
);

  localparam int unsigned SrcWidth = (NumMasters > 1) ? $clog2(NumMasters) : 1;

  // Request stream, router to bank
  logic                req_valid;
  logic                req_ready;
  l2_req_t             req;
  logic [SrcWidth-1:0] req_src;    // Issuing requester

  // Response stream, bank to return path
  logic                rsp_valid;
  logic                rsp_ready;
  l2_rsp_t             rsp;
  logic [SrcWidth-1:0] rsp_dst;    // Requester to return to

  modport router (
    output req_valid, req, req_src,
    input  req_ready
  );

  modport bank (
    input  req_valid, req, req_src, rsp_ready,
    output req_ready, rsp_valid, rsp, rsp_dst
  );

  // Return side of the response stream
  modport ret (
    input  rsp_valid, rsp, rsp_dst,
    output rsp_ready
  );

endinterface

`default_nettype wire

/* rtl/stream_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream arbiter
// Round-robin N-to-1 with grant lock-in
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module stream_arbiter #(
  parameter int unsigned NumInp    = 4,
  parameter type         payload_t = logic,
  localparam int unsigned IdxWidth = (NumInp > 1) ? $clog2(NumInp) : 1
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic     [NumInp-1:0]      valid_i,
  output logic     [NumInp-1:0]      ready_o,
  input  payload_t [NumInp-1:0]      data_i,
  output logic                       valid_o,
  input  logic                       ready_i,
  output payload_t                   data_o,
  output logic     [IdxWidth-1:0]    idx_o
);

  logic [IdxWidth-1:0] rr_q;        // Highest priority input
  logic                lock_q;      // Offered item still pending
  logic [IdxWidth-1:0] lock_idx_q;
  logic [IdxWidth-1:0] sel_idx;
  logic                sel_found;

  // First valid input at or after the pointer
  always_comb begin : p_select
    int unsigned cand;
    sel_idx   = rr_q;
    sel_found = 1'b0;
    for (int unsigned k = 0; k < NumInp; k++) begin
      cand = (rr_q + k) % NumInp;
      if (!sel_found && valid_i[cand]) begin
        sel_idx   = IdxWidth'(cand);
        sel_found = 1'b1;
      end
    end
  end

  assign idx_o   = lock_q ? lock_idx_q : sel_idx;  // Never withdraw an offer
  assign valid_o = valid_i[idx_o];
  assign data_o  = data_i[idx_o];

  always_comb begin
    ready_o = '0;
    ready_o[idx_o] = valid_o && ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= valid_o && !ready_i;
      lock_idx_q <= idx_o;
      if (valid_o && ready_i) begin
        // Move past the winner
        rr_q <= (idx_o == IdxWidth'(NumInp - 1)) ? '0 : idx_o + 1'b1;
      end
    end
  end

  // Some input is on offer whenever any input is valid
  a_work_conserving: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|valid_i) |-> valid_o);

endmodule

`default_nettype wire

/* rtl/l2_req_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 request router
// Bank select and per-bank arbitration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_req_router
  import l2_pkg::*;
#(
  parameter int unsigned NumMasters = 4,
  parameter int unsigned NumBanks   = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic    [NumMasters-1:0]     req_valid_i,
  output logic    [NumMasters-1:0]     req_ready_o,
  input  l2_req_t [NumMasters-1:0]     req_i,
  l2_bank_if.router                    bank_o [NumBanks]
);

  localparam int unsigned BankSelWidth = (NumBanks > 1) ? $clog2(NumBanks) : 1;

  logic [NumMasters-1:0][BankSelWidth-1:0] bank_sel;
  logic [NumBanks-1:0][NumMasters-1:0]     bank_valid;   // Valids seen by each bank
  logic [NumBanks-1:0][NumMasters-1:0]     bank_ready;   // Grants from each bank

  // Word interleaving, bank index sits right above the byte offset
  always_comb begin
    for (int unsigned m = 0; m < NumMasters; m++) begin
      if (NumBanks > 1) begin
        bank_sel[m] = req_i[m].addr[ByteOffsetBits +: BankSelWidth];
      end else begin
        bank_sel[m] = '0;
      end
    end
  end

  always_comb begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      for (int unsigned m = 0; m < NumMasters; m++) begin
        bank_valid[b][m] = req_valid_i[m] && (bank_sel[m] == BankSelWidth'(b));
      end
    end
  end

  // A requester targets one bank, so at most one grant per requester
  always_comb begin
    req_ready_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      req_ready_o |= bank_ready[b];
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank_arb
    stream_arbiter #(
      .NumInp    (NumMasters),
      .payload_t (l2_req_t  )
    ) i_arb (
      .clk_i   (clk_i              ),
      .rst_n_i (rst_n_i            ),
      .valid_i (bank_valid[b]      ),
      .ready_o (bank_ready[b]      ),
      .data_i  (req_i              ),
      .valid_o (bank_o[b].req_valid),
      .ready_i (bank_o[b].req_ready),
      .data_o  (bank_o[b].req      ),
      .idx_o   (bank_o[b].req_src  )   // Carried along as the return address
    );
  end

  // Requesters keep their offer until the bank takes it
  for (genvar m = 0; m < NumMasters; m++) begin : gen_req_check
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_valid_i[m] && !req_ready_o[m] |=> req_valid_i[m] && $stable(req_i[m]));
  end

endmodule

`default_nettype wire

/* rtl/l2_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 bank
// Adapter, strobed SRAM and response slot
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_bank
  import l2_pkg::*;
#(
  parameter int unsigned NumMasters   = 4,
  parameter int unsigned NumBanks     = 4,
  parameter int unsigned BankNumWords = 256
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  l2_bank_if.bank bus
);

  localparam int unsigned SrcWidth      = (NumMasters > 1) ? $clog2(NumMasters) : 1;
  localparam int unsigned RowWidth      = $clog2(BankNumWords);
  localparam int unsigned BankBits      = $clog2(NumBanks);
  localparam int unsigned BankAddrIndex = ByteOffsetBits + BankBits;

  logic [AddrWidth-1:0] addr_scrambled;
  logic [RowWidth-1:0]  row;
  logic                 req_fire;

  logic [DataWidth-1:0] mem_q [BankNumWords];   // Single-port array

  l2_rsp_t              rsp_q;
  logic [SrcWidth-1:0]  rsp_dst_q;
  logic                 rsp_valid_q;

  // Cut the bank index out so each bank sees a dense row space
  assign addr_scrambled = AddrWidth'({bus.req.addr[AddrWidth-1:BankAddrIndex],
                                      bus.req.addr[ByteOffsetBits-1:0]});
  assign row = addr_scrambled[ByteOffsetBits +: RowWidth];  // Upper bits alias

  // Accept when the slot is free or drains on this edge
  assign bus.req_ready = !rsp_valid_q || bus.rsp_ready;
  assign req_fire      = bus.req_valid && bus.req_ready;

  // Byte-strobed write port
  always_ff @(posedge clk_i) begin
    if (req_fire && bus.req.write) begin
      for (int unsigned i = 0; i < StrbWidth; i++) begin
        if (bus.req.strb[i]) begin
          mem_q[row][8*i +: 8] <= bus.req.wdata[8*i +: 8];
        end
      end
    end
  end

  // Response slot valid
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Read data lands here one cycle after the request
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_q.rdata <= bus.req.write ? '0 : mem_q[row];  // Write ack carries zero
      rsp_q.tag   <= bus.req.tag;
      rsp_dst_q   <= bus.req_src;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp       = rsp_q;
  assign bus.rsp_dst   = rsp_dst_q;

  // A stalled request stays on offer unchanged
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.req_valid && !bus.req_ready |=>
      bus.req_valid && $stable(bus.req) && $stable(bus.req_src));

endmodule

`default_nettype wire

/* rtl/l2_rsp_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 response router
// Per-requester arbitration over banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_rsp_router
  import l2_pkg::*;
#(
  parameter int unsigned NumMasters = 4,
  parameter int unsigned NumBanks   = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  l2_bank_if.ret                   bank_i [NumBanks],
  output logic    [NumMasters-1:0] rsp_valid_o,
  input  logic    [NumMasters-1:0] rsp_ready_i,
  output l2_rsp_t [NumMasters-1:0] rsp_o
);

  localparam int unsigned SrcWidth = (NumMasters > 1) ? $clog2(NumMasters) : 1;

  logic    [NumBanks-1:0]                 bank_valid;
  l2_rsp_t [NumBanks-1:0]                 bank_rsp;
  logic    [NumBanks-1:0][SrcWidth-1:0]   bank_dst;
  logic    [NumMasters-1:0][NumBanks-1:0] mst_valid;
  logic    [NumMasters-1:0][NumBanks-1:0] mst_ready;

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    assign bank_valid[b] = bank_i[b].rsp_valid;
    assign bank_rsp[b]   = bank_i[b].rsp;
    assign bank_dst[b]   = bank_i[b].rsp_dst;
    // Only the destination arbiter can grant this bank
    assign bank_i[b].rsp_ready = mst_ready[bank_dst[b]][b];
  end

  // Decode destinations into one valid per requester
  always_comb begin
    for (int unsigned m = 0; m < NumMasters; m++) begin
      for (int unsigned b = 0; b < NumBanks; b++) begin
        mst_valid[m][b] = bank_valid[b] && (bank_dst[b] == SrcWidth'(m));
      end
    end
  end

  for (genvar m = 0; m < NumMasters; m++) begin : gen_mst_arb
    stream_arbiter #(
      .NumInp    (NumBanks),
      .payload_t (l2_rsp_t)
    ) i_arb (
      .clk_i   (clk_i         ),
      .rst_n_i (rst_n_i       ),
      .valid_i (mst_valid[m]  ),
      .ready_o (mst_ready[m]  ),
      .data_i  (bank_rsp      ),
      .valid_o (rsp_valid_o[m]),
      .ready_i (rsp_ready_i[m]),
      .data_o  (rsp_o[m]      ),
      .idx_o   (              )   // Source bank not needed upstream
    );
  end

endmodule

`default_nettype wire

/* rtl/l2_memory.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 memory top
// Banked shared memory, plain ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module l2_memory
  import l2_pkg::*;
#(
  parameter int unsigned NumMasters   = 4,
  parameter int unsigned NumBanks     = 4,    // Power of two
  parameter int unsigned BankNumWords = 256   // Power of two
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // Request side
  input  logic [NumMasters-1:0]                req_valid_i,
  output logic [NumMasters-1:0]                req_ready_o,
  input  logic [NumMasters-1:0][AddrWidth-1:0] req_addr_i,
  input  logic [NumMasters-1:0]                req_write_i,
  input  logic [NumMasters-1:0][DataWidth-1:0] req_wdata_i,
  input  logic [NumMasters-1:0][StrbWidth-1:0] req_strb_i,
  input  logic [NumMasters-1:0][TagWidth-1:0]  req_tag_i,
  // Response side
  output logic [NumMasters-1:0]                rsp_valid_o,
  input  logic [NumMasters-1:0]                rsp_ready_i,
  output logic [NumMasters-1:0][DataWidth-1:0] rsp_rdata_o,
  output logic [NumMasters-1:0][TagWidth-1:0]  rsp_tag_o
);

  l2_req_t [NumMasters-1:0] req;
  l2_rsp_t [NumMasters-1:0] rsp;

  for (genvar m = 0; m < NumMasters; m++) begin : gen_pack
    assign req[m] = '{
      addr:  req_addr_i[m],
      write: req_write_i[m],
      wdata: req_wdata_i[m],
      strb:  req_strb_i[m],
      tag:   req_tag_i[m]
    };
    assign rsp_rdata_o[m] = rsp[m].rdata;
    assign rsp_tag_o[m]   = rsp[m].tag;
  end

  l2_bank_if #(.NumMasters(NumMasters)) bank_bus [NumBanks] ();

  l2_req_router #(
    .NumMasters (NumMasters),
    .NumBanks   (NumBanks  )
  ) i_req_router (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req        ),
    .bank_o      (bank_bus   )
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
    l2_bank #(
      .NumMasters   (NumMasters  ),
      .NumBanks     (NumBanks    ),
      .BankNumWords (BankNumWords)
    ) i_bank (
      .clk_i   (clk_i      ),
      .rst_n_i (rst_n_i    ),
      .bus     (bank_bus[b])
    );
  end

  l2_rsp_router #(
    .NumMasters (NumMasters),
    .NumBanks   (NumBanks  )
  ) i_rsp_router (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .bank_i      (bank_bus   ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp        )
  );

endmodule

`default_nettype wire

/* tests/tb_l2_memory.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 memory testbench
// Reference model, scoreboard and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_l2_memory
  import l2_pkg::*;
;

  localparam int unsigned NumMasters   = 4;
  localparam int unsigned NumBanks     = 4;
  localparam int unsigned BankNumWords = 256;
  localparam int unsigned RandReqs     = 40;  // Per requester, per random test
  localparam int unsigned TotalReqs    = 2 + 5 + 16 + 2 * NumMasters * RandReqs;
  localparam int unsigned RegionBytes  = 1024;  // One private region per requester

  logic clk_i;
  logic rst_n_i;
  logic [NumMasters-1:0]                req_valid_i;
  logic [NumMasters-1:0]                req_ready_o;
  logic [NumMasters-1:0][AddrWidth-1:0] req_addr_i;
  logic [NumMasters-1:0]                req_write_i;
  logic [NumMasters-1:0][DataWidth-1:0] req_wdata_i;
  logic [NumMasters-1:0][StrbWidth-1:0] req_strb_i;
  logic [NumMasters-1:0][TagWidth-1:0]  req_tag_i;
  logic [NumMasters-1:0]                rsp_valid_o;
  logic [NumMasters-1:0]                rsp_ready_i;
  logic [NumMasters-1:0][DataWidth-1:0] rsp_rdata_o;
  logic [NumMasters-1:0][TagWidth-1:0]  rsp_tag_o;

  // Per-requester driver state, one process per requester
  logic    v_q    [NumMasters];
  l2_req_t req_q  [NumMasters];
  tag_t    next_tag [NumMasters];

  // Scoreboard keyed by tag
  logic    exp_valid [NumMasters][2**TagWidth];
  l2_rsp_t exp_rsp   [NumMasters][2**TagWidth];
  data_t   model [int unsigned];   // Word index to contents

  logic    held     [NumMasters];
  l2_rsp_t held_rsp [NumMasters];
  logic    stall_en;
  int      errors;
  int      checks;
  int      test_errors;

  for (genvar m = 0; m < NumMasters; m++) begin : gen_drive
    assign req_valid_i[m] = v_q[m];
    assign req_addr_i[m]  = req_q[m].addr;
    assign req_write_i[m] = req_q[m].write;
    assign req_wdata_i[m] = req_q[m].wdata;
    assign req_strb_i[m]  = req_q[m].strb;
    assign req_tag_i[m]   = req_q[m].tag;
  end

  l2_memory #(
    .NumMasters   (NumMasters  ),
    .NumBanks     (NumBanks    ),
    .BankNumWords (BankNumWords)
  ) dut_i (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i ),
    .req_write_i (req_write_i),
    .req_wdata_i (req_wdata_i),
    .req_strb_i  (req_strb_i ),
    .req_tag_i   (req_tag_i  ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_tag_o   (rsp_tag_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Applies a request to the model, returns the predicted read data
  function automatic data_t expected_rdata(addr_t addr, logic write, data_t wdata,
                                           strb_t strb);
    int unsigned w;
    data_t       cur;
    w = (addr >> ByteOffsetBits) % (NumBanks * BankNumWords);  // Aliasing
    if (!write) return model[w];
    cur = model.exists(w) ? model[w] : '0;
    for (int i = 0; i < StrbWidth; i++) begin
      if (strb[i]) cur[8*i +: 8] = wdata[8*i +: 8];
    end
    model[w] = cur;
    return '0;
  endfunction

  task automatic check_rsp(string name, l2_rsp_t exp, l2_rsp_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
    end
  endtask

  task automatic check_tag(string name, tag_t exp, tag_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
    end
  endtask

  // Called at a rising edge, returns at the edge of the transfer
  task automatic issue(int m, addr_t addr, logic write, data_t wdata, strb_t strb);
    tag_t tag;
    tag = next_tag[m];
    while (exp_valid[m][tag]) @(posedge clk_i);  // Tag still in flight
    v_q[m]   <= 1'b1;
    req_q[m] <= '{addr: addr, write: write, wdata: wdata, strb: strb, tag: tag};
    do @(posedge clk_i); while (!req_ready_o[m]);
    exp_rsp[m][tag].rdata = expected_rdata(addr, write, wdata, strb);
    exp_rsp[m][tag].tag   = tag;
    exp_valid[m][tag]     = 1'b1;
    next_tag[m]           = tag + 1'b1;
    v_q[m] <= 1'b0;
  endtask

  function automatic int outstanding();
    int n;
    n = 0;
    foreach (exp_valid[m, t]) if (exp_valid[m][t]) n++;
    return n;
  endfunction

  task automatic drain();
    while (outstanding() != 0) @(posedge clk_i);
  endtask

  task automatic finish_test(string name);
    $display("test %-14s %s (%0d errors)", name,
             (errors == test_errors) ? "ok" : "FAILED", errors - test_errors);
    test_errors = errors;
  endtask

  task automatic rand_traffic(int m);
    addr_t       addr;
    logic        write;
    strb_t       strb;
    int unsigned w;
    for (int i = 0; i < RandReqs; i++) begin
      addr  = addr_t'(m * RegionBytes + ($urandom % BankNumWords) * StrbWidth);
      w     = (addr >> ByteOffsetBits) % (NumBanks * BankNumWords);
      write = !model.exists(w) || ($urandom % 2 == 1);  // Never read undefined words
      strb  = model.exists(w) ? strb_t'($urandom % 15 + 1) : '1;
      issue(m, addr, write, $urandom, strb);
      repeat ($urandom % 3) @(posedge clk_i);
    end
  endtask

  // Checks every response transfer and holds during stalls
  always @(posedge clk_i) begin : compare
    l2_rsp_t cur;
    tag_t    t;
    if (rst_n_i) begin
      for (int m = 0; m < NumMasters; m++) begin
        cur = '{rdata: rsp_rdata_o[m], tag: rsp_tag_o[m]};
        if (held[m]) begin
          if (!rsp_valid_o[m]) begin
            errors++;
            $display("Requester %0d withdrew a stalled response", m);
          end else begin
            check_rsp($sformatf("rsp_rdata_o/rsp_tag_o[%0d] while stalled", m),
                      held_rsp[m], cur);
          end
        end
        if (rsp_valid_o[m] && rsp_ready_i[m]) begin
          t = rsp_tag_o[m];
          if (!exp_valid[m][t]) begin
            errors++;
            $display("Requester %0d got a response with unknown or repeated tag %0d", m, t);
          end else begin
            check_rsp($sformatf("rsp_rdata_o/rsp_tag_o[%0d]", m), exp_rsp[m][t], cur);
            exp_valid[m][t] = 1'b0;
          end
        end
        held[m]     = rsp_valid_o[m] && !rsp_ready_i[m];
        held_rsp[m] = cur;
      end
    end
  end

  // Random back-pressure
  always @(posedge clk_i) begin
    for (int m = 0; m < NumMasters; m++) begin
      rsp_ready_i[m] <= stall_en ? ($urandom % 3 != 0) : 1'b1;
    end
  end

  initial begin : watchdog
    repeat (TotalReqs * 20 + 10) @(posedge clk_i);
    $display("Watchdog expired with %0d responses still outstanding", outstanding());
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    void'($urandom(85062));
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    stall_en    = 1'b0;
    rst_n_i     <= 1'b0;
    rsp_ready_i <= '1;
    for (int m = 0; m < NumMasters; m++) begin
      v_q[m]      <= 1'b0;
      req_q[m]    <= '0;
      next_tag[m] = '0;
      held[m]     = 1'b0;
      held_rsp[m] = '0;
      for (int t = 0; t < 2**TagWidth; t++) exp_valid[m][t] = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // 1: idle after reset
    repeat (5) begin
      @(posedge clk_i);
      if (rsp_valid_o !== '0) begin
        errors++;
        $display("[ERROR] rsp_valid_o expected 0x0 actual 0x%h", rsp_valid_o);
      end
    end
    finish_test("reset");

    // 2: write then read, one-cycle latency
    issue(0, 32'h40, 1'b1, 32'hcafe_f00d, '1);
    @(posedge clk_i);
    issue(0, 32'h40, 1'b0, '0, '0);
    @(posedge clk_i);
    if (!rsp_valid_o[0]) begin
      errors++;
      $display("Read response not valid on the cycle after acceptance");
    end
    check_tag("rsp_tag_o[0]", tag_t'(next_tag[0] - 1'b1), rsp_tag_o[0]);
    drain();
    finish_test("write_read");

    // 3: byte strobes
    issue(0, 32'h80, 1'b1, 32'h1122_3344, 4'hf);
    issue(0, 32'h80, 1'b1, 32'haaaa_aaaa, 4'h1);
    issue(0, 32'h80, 1'b1, 32'hbbbb_bbbb, 4'h4);
    issue(0, 32'h80, 1'b1, 32'hcccc_cccc, 4'h8);
    issue(0, 32'h80, 1'b0, '0, '0);
    drain();
    finish_test("strobes");

    // 4: consecutive words across all banks
    for (int i = 0; i < 8; i++) issue(1, addr_t'(RegionBytes + 4 * i), 1'b1, $urandom, '1);
    for (int i = 0; i < 8; i++) issue(1, addr_t'(RegionBytes + 4 * i), 1'b0, '0, '0);
    drain();
    finish_test("interleave");

    // 5: concurrent random traffic
    for (int m = 0; m < NumMasters; m++) begin
      fork
        automatic int mm = m;
        rand_traffic(mm);
      join_none
    end
    wait fork;
    drain();
    finish_test("random");

    // 6: same with back-pressure
    stall_en = 1'b1;
    for (int m = 0; m < NumMasters; m++) begin
      fork
        automatic int mm = m;
        rand_traffic(mm);
      join_none
    end
    wait fork;
    drain();
    stall_en = 1'b0;
    finish_test("backpressure");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
rtl/l2_pkg.sv
rtl/l2_bank_if.sv
rtl/stream_arbiter.sv
rtl/l2_req_router.sv
rtl/l2_bank.sv
rtl/l2_rsp_router.sv
rtl/l2_memory.sv
tests/tb_l2_memory.sv

/* run.sh */
#!/bin/sh
# Build and run the L2 memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_l2_memory \
  -Mdir obj_dir -o Vtb_l2_memory \
  && ./obj_dir/Vtb_l2_memory > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1
